//--- countConnected.f
+incdir+rtl
rtl/countConnectedPkg.sv
rtl/delayLine.sv
rtl/monotonizeStage.sv
rtl/newSeedProducer.sv
rtl/explorationPipe.sv
rtl/loopController.sv
rtl/countConnectedCore.sv
testbench/countConnectedTb.sv

//--- rtl/countConnectedCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "countConnected_config.svh"

module countConnectedCore (
    input  logic clk,
    input  logic rstN,
    input  countConnectedPkg::graphWord graphIn,
    input  logic graphInValid,
    input  logic [`TAG_WIDTH-1:0] tagIn,
    output logic request,
    output logic done,
    output logic [`COUNT_WIDTH-1:0] connectCount,
    output logic [`TAG_WIDTH-1:0] tagOut
);

    // Return delays so every part of a slot meets again after LOOP_DEPTH cycles
    // runEnd goes straight back, DATA_IN_LATENCY early for the request
    localparam int REDUCED_RETURN = `LOOP_DEPTH - 1 - `SEED_DEPTH - `EXPLORE_DEPTH;
    localparam int EXTENDED_RETURN = `LOOP_DEPTH - 1 - `EXPLORE_DEPTH;
    localparam int GRAB_RETURN = `LOOP_DEPTH - 1 - `EXPLORE_DEPTH - `SUMMARY_DEPTH;
    localparam int META_RETURN = `LOOP_DEPTH - 1 - `SEED_DEPTH;

    countConnectedPkg::graphWord graphStart;
    countConnectedPkg::graphWord leftover;
    countConnectedPkg::graphWord curExtending;
    countConnectedPkg::graphWord reducedBack;
    countConnectedPkg::graphWord extendedBack;
    countConnectedPkg::slotMeta metaOut;
    countConnectedPkg::slotMeta metaBack;
    countConnectedPkg::exploreResult result;
    logic incrementCount;
    logic runEnd;
    logic grabSeed;
    logic grabSeedBack;

    loopController uController (
        .clk(clk), .rstN(rstN),
        .graphIn(graphIn), .graphInValid(graphInValid), .tagIn(tagIn),
        .runEndIn(runEnd), .reducedIn(reducedBack), .metaIn(metaBack),
        .incrementCount(incrementCount),
        .graphStart(graphStart), .metaOut(metaOut),
        .request(request), .done(done), .connectCount(connectCount), .tagOut(tagOut)
    );

    newSeedProducer uSeed (
        .clk(clk), .graphIn(graphStart), .extendedIn(extendedBack), .grabSeed(grabSeedBack),
        .graphOut(leftover), .curExtending(curExtending), .incrementCount(incrementCount)
    );

    explorationPipe uExplore (
        .clk(clk), .leftover(leftover), .curExtending(curExtending),
        .result(result), .runEnd(runEnd), .grabSeed(grabSeed)
    );

    delayLine #(.WIDTH(`GRAPH_WIDTH), .CYCLES(REDUCED_RETURN)) uReducedLoop (
        .clk(clk), .rstN(rstN), .d(result.reduced), .q(reducedBack)
    );

    delayLine #(.WIDTH(`GRAPH_WIDTH), .CYCLES(EXTENDED_RETURN)) uExtendedLoop (
        .clk(clk), .rstN(rstN), .d(result.extended), .q(extendedBack)
    );

    delayLine #(.WIDTH(1), .CYCLES(GRAB_RETURN), .RESET_VALUE(1'b1)) uGrabSeedLoop (
        .clk(clk), .rstN(rstN), .d(grabSeed), .q(grabSeedBack)
    );

    delayLine #(.WIDTH($bits(countConnectedPkg::slotMeta)), .CYCLES(META_RETURN)) uMetaLoop (
        .clk(clk), .rstN(rstN), .d(metaOut), .q(metaBack)
    );

endmodule

`default_nettype wire

//--- rtl/countConnectedPkg.sv
`default_nettype none

`include "countConnected_config.svh"

package countConnectedPkg;

    // One graph, seen either as a flat bit vector or as groups of four vertices
    typedef union packed {
        logic [`GRAPH_WIDTH-1:0] flat;
        logic [`GRAPH_WIDTH/4-1:0][3:0] groups;
    } graphWord;

    // Bookkeeping that travels with each slot around the ring
    typedef struct packed {
        logic valid;
        logic [`COUNT_WIDTH-1:0] count;
        logic [`TAG_WIDTH-1:0] tag;
    } slotMeta;

    // Leftover graph after removing the explored part, and the explored part
    typedef struct packed {
        graphWord reduced;
        graphWord extended;
    } exploreResult;

endpackage

`default_nettype wire

//--- rtl/countConnected_config.svh
`ifndef COUNT_CONNECTED_CONFIG_SVH
`define COUNT_CONNECTED_CONFIG_SVH

// Graph and result widths
`define GRAPH_WIDTH 128
`define TAG_WIDTH 8
`define COUNT_WIDTH 6

// Pipeline depths in cycles
`define SEED_DEPTH 3
`define EXPLORE_DEPTH 9
`define SUMMARY_DEPTH 2
`define LOOP_DEPTH 16
`define DATA_IN_LATENCY 1

`endif

//--- rtl/delayLine.sv
`timescale 1ns/1ps
`default_nettype none

module delayLine #(
    parameter int WIDTH = 1,
    parameter int CYCLES = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  logic clk,
    input  logic rstN,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [CYCLES-1:0][WIDTH-1:0] stages;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stages <= {CYCLES{RESET_VALUE}};
        end else begin
            stages[0] <= d;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign q = stages[CYCLES-1];

endmodule

`default_nettype wire

//--- rtl/explorationPipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "countConnected_config.svh"

module explorationPipe (
    input  logic clk,
    input  countConnectedPkg::graphWord leftover,
    input  countConnectedPkg::graphWord curExtending,
    output countConnectedPkg::exploreResult result,
    output logic runEnd,
    output logic grabSeed
);

    localparam int GROUPS = `GRAPH_WIDTH / 4;
    localparam int STAGE_CYCLES = 2;
    localparam int STAGES = 4;

    countConnectedPkg::graphWord setChain [0:STAGES];
    countConnectedPkg::graphWord maskChain [0:STAGES];
    countConnectedPkg::graphWord midpoint;
    logic [GROUPS-1:0] groupNonEmpty;
    logic [GROUPS-1:0] groupSame;

    assign setChain[0]  = curExtending;
    assign maskChain[0] = leftover;

    // Up, down, up, down; the leftover graph follows each stage as its mask
    for (genvar i = 0; i < STAGES; i++) begin : gClosure
        monotonizeStage #(.upward(i % 2 == 0)) uStage (
            .clk   (clk),
            .setIn (setChain[i]),
            .mask  (maskChain[i]),
            .setOut(setChain[i+1])
        );

        delayLine #(.WIDTH(`GRAPH_WIDTH), .CYCLES(STAGE_CYCLES)) uMaskDelay (
            .clk (clk),
            .rstN(1'b1),
            .d   (maskChain[i]),
            .q   (maskChain[i+1])
        );
    end

    // Midpoint after the third stage, lined up with the split output
    delayLine #(.WIDTH(`GRAPH_WIDTH), .CYCLES(STAGE_CYCLES + 1)) uMidpointDelay (
        .clk (clk),
        .rstN(1'b1),
        .d   (setChain[STAGES-1]),
        .q   (midpoint)
    );

    always_ff @(posedge clk) begin
        result.reduced.flat <= maskChain[STAGES].flat & ~setChain[STAGES].flat;
        result.extended     <= setChain[STAGES];
    end

    // Summary in two levels of reduction
    always_ff @(posedge clk) begin
        for (int g = 0; g < GROUPS; g++) begin
            groupNonEmpty[g] <= |result.reduced.groups[g];
            groupSame[g]     <= result.extended.groups[g] == midpoint.groups[g];
        end
        runEnd <= ~|groupNonEmpty;
        // The last down closure added nothing, so the component is complete
        grabSeed <= ~|groupNonEmpty | &groupSame;
    end

endmodule

`default_nettype wire

//--- rtl/loopController.sv
`timescale 1ns/1ps
`default_nettype none

`include "countConnected_config.svh"

module loopController (
    input  logic clk,
    input  logic rstN,
    input  countConnectedPkg::graphWord graphIn,
    input  logic graphInValid,
    input  logic [`TAG_WIDTH-1:0] tagIn,
    input  logic runEndIn,
    input  countConnectedPkg::graphWord reducedIn,
    input  countConnectedPkg::slotMeta metaIn,
    input  logic incrementCount,
    output countConnectedPkg::graphWord graphStart,
    output countConnectedPkg::slotMeta metaOut,
    output logic request,
    output logic done,
    output logic [`COUNT_WIDTH-1:0] connectCount,
    output logic [`TAG_WIDTH-1:0] tagOut
);

    logic runEndStart;
    countConnectedPkg::slotMeta metaStart;
    countConnectedPkg::slotMeta metaSeed;

    // A slot coming back with its run ended asks for a new graph
    assign request = runEndIn;

    // After reset every slot counts as ended, so the ring fills with fresh graphs
    delayLine #(.WIDTH(1), .CYCLES(`DATA_IN_LATENCY), .RESET_VALUE(1'b1)) uRunEndDelay (
        .clk (clk),
        .rstN(rstN),
        .d   (runEndIn),
        .q   (runEndStart)
    );

    always_ff @(posedge clk) begin
        graphStart   <= runEndStart ? graphIn : reducedIn;
        connectCount <= metaIn.count;
        tagOut       <= metaIn.tag;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            metaStart <= '0;
            metaOut   <= '0;
            done      <= 1'b0;
        end else begin
            if (runEndStart) begin
                metaStart.valid <= graphInValid;
                metaStart.count <= '0;
                metaStart.tag   <= tagIn;
            end else begin
                metaStart <= metaIn;
            end
            metaOut.valid <= metaSeed.valid;
            metaOut.count <= metaSeed.count + {{(`COUNT_WIDTH-1){1'b0}}, incrementCount};
            metaOut.tag   <= metaSeed.tag;
            done          <= runEndStart & metaIn.valid;
        end
    end

    // Metadata waits for the increment from the seed stage
    delayLine #(
        .WIDTH($bits(countConnectedPkg::slotMeta)),
        .CYCLES(`SEED_DEPTH - 1)
    ) uMetaDelay (
        .clk (clk),
        .rstN(rstN),
        .d   (metaStart),
        .q   (metaSeed)
    );

endmodule

`default_nettype wire

//--- rtl/monotonizeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "countConnected_config.svh"

module monotonizeStage #(
    parameter bit upward = 1'b1
) (
    input  logic clk,
    input  countConnectedPkg::graphWord setIn,
    input  countConnectedPkg::graphWord mask,
    output countConnectedPkg::graphWord setOut
);

    logic [`GRAPH_WIDTH-1:0] lowClosed;
    countConnectedPkg::graphWord maskD;

    // Closes the set along the hypercube dimensions firstDim to lastDim
    function automatic logic [`GRAPH_WIDTH-1:0] closeDims(
        input logic [`GRAPH_WIDTH-1:0] s,
        input int firstDim,
        input int lastDim
    );
        logic [`GRAPH_WIDTH-1:0] r;
        r = s;
        for (int d = firstDim; d <= lastDim; d++) begin
            for (int v = 0; v < `GRAPH_WIDTH; v++) begin
                // Each vertex inherits from its neighbour one step below or above
                if (upward && v[d]) begin
                    r[v] = r[v] | r[v ^ (1 << d)];
                end else if (!upward && !v[d]) begin
                    r[v] = r[v] | r[v | (1 << d)];
                end
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        lowClosed   <= closeDims(setIn.flat, 0, 3);
        maskD       <= mask;
        setOut.flat <= closeDims(lowClosed, 4, 6) & maskD.flat;
    end

endmodule

`default_nettype wire

//--- rtl/newSeedProducer.sv
`timescale 1ns/1ps
`default_nettype none

`include "countConnected_config.svh"

module newSeedProducer (
    input  logic clk,
    input  countConnectedPkg::graphWord graphIn,
    input  countConnectedPkg::graphWord extendedIn,
    input  logic grabSeed,
    output countConnectedPkg::graphWord graphOut,
    output countConnectedPkg::graphWord curExtending,
    output logic incrementCount
);

    localparam int GROUPS = `GRAPH_WIDTH / 4;
    localparam int QUADS = GROUPS / 4;

    logic [GROUPS-1:0] hasBit4;
    logic [GROUPS-1:0] firstGroup;
    logic [QUADS-1:0] hasBit16;
    logic [QUADS:0] quadChain;
    logic isEmpty;
    countConnectedPkg::graphWord graphSel;
    countConnectedPkg::graphWord seed;

    // Graph arrives at the selection cycle together with firstGroup
    delayLine #(.WIDTH(`GRAPH_WIDTH), .CYCLES(`SEED_DEPTH - 1)) uGraphDelay (
        .clk (clk),
        .rstN(1'b1),
        .d   (graphIn),
        .q   (graphSel)
    );

    // quadChain[q] is high when every quad below q is empty
    always_comb begin
        quadChain[0] = 1'b1;
        for (int q = 0; q < QUADS; q++) begin
            hasBit16[q]    = |hasBit4[4*q +: 4];
            quadChain[q+1] = quadChain[q] & ~hasBit16[q];
        end
    end

    always_ff @(posedge clk) begin
        for (int g = 0; g < GROUPS; g++) begin
            hasBit4[g] <= |graphIn.groups[g];
        end
        for (int q = 0; q < QUADS; q++) begin
            for (int k = 0; k < 4; k++) begin
                firstGroup[4*q+k] <= quadChain[q]
                    && ((hasBit4[4*q +: 4] & ((4'b0001 << k) - 4'b0001)) == '0);
            end
        end
        isEmpty <= quadChain[QUADS];
    end

    // Lowest set bit, kept only inside the first non-empty group
    always_comb begin
        for (int g = 0; g < GROUPS; g++) begin
            seed.groups[g] = firstGroup[g]
                ? (graphSel.groups[g] & (~graphSel.groups[g] + 4'b0001)) : 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        graphOut     <= graphSel;
        curExtending <= grabSeed ? seed : extendedIn;
    end

    // A seed only counts when the leftover graph still holds a vertex
    assign incrementCount = grabSeed & ~isEmpty;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f countConnected.f --top-module countConnectedTb \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi
exit 0

//--- testbench/countConnectedTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "countConnected_config.svh"

module countConnectedTb;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int TABLE_SIZE = 12;
    localparam int RANDOM_GRAPHS = 40;
    localparam int NUM_JOBS = TABLE_SIZE + RANDOM_GRAPHS;
    localparam longint TIMEOUT_NS = longint'(NUM_JOBS) * 8 * `LOOP_DEPTH * CLK_PERIOD
        + longint'(RESET_CYCLES + 8 * `LOOP_DEPTH) * CLK_PERIOD;

    typedef struct packed {
        logic [`GRAPH_WIDTH-1:0] graph;
        logic valid;
        logic [`COUNT_WIDTH-1:0] count;
    } jobEntry;

    logic clk = 1'b0;
    logic rstN = 1'b0;
    countConnectedPkg::graphWord graphIn = '0;
    logic graphInValid = 1'b0;
    logic [`TAG_WIDTH-1:0] tagIn = '0;
    logic request;
    logic done;
    logic [`COUNT_WIDTH-1:0] connectCount;
    logic [`TAG_WIDTH-1:0] tagOut;

    jobEntry jobs [NUM_JOBS];
    logic [NUM_JOBS-1:0] finished = '0;
    // Recent request samples, oldest at the top
    logic [`DATA_IN_LATENCY:0] requestHist = '0;
    int nextJob = 0;
    int validJobs = 0;
    int completed = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    logic [31:0] rngState;

    countConnectedCore DUT (
        .clk(clk), .rstN(rstN),
        .graphIn(graphIn), .graphInValid(graphInValid), .tagIn(tagIn),
        .request(request), .done(done), .connectCount(connectCount), .tagOut(tagOut)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] r;
        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    function automatic jobEntry makeEntry(
        input logic [`GRAPH_WIDTH-1:0] g,
        input logic v,
        input logic [`COUNT_WIDTH-1:0] c
    );
        jobEntry e;
        e.graph = g;
        e.valid = v;
        e.count = c;
        return e;
    endfunction

    // Every vertex of g that lies above (or below) some vertex of s
    function automatic logic [`GRAPH_WIDTH-1:0] closeSet(
        input logic [`GRAPH_WIDTH-1:0] s,
        input logic [`GRAPH_WIDTH-1:0] g,
        input logic upward
    );
        logic [`GRAPH_WIDTH-1:0] r;
        r = '0;
        for (int v = 0; v < `GRAPH_WIDTH; v++) begin
            if (g[v]) begin
                for (int u = 0; u < `GRAPH_WIDTH; u++) begin
                    if (s[u] && (upward ? ((u & v) == u) : ((u & v) == v))) begin
                        r[v] = 1'b1;
                    end
                end
            end
        end
        return r;
    endfunction

    // Seed at the lowest vertex, grow until stable, remove, repeat
    function automatic int countComponents(input logic [`GRAPH_WIDTH-1:0] g);
        logic [`GRAPH_WIDTH-1:0] left;
        logic [`GRAPH_WIDTH-1:0] comp;
        logic [`GRAPH_WIDTH-1:0] grown;
        int n;
        n = 0;
        left = g;
        while (left != '0) begin
            comp = left & (~left + 1'b1);
            grown = closeSet(closeSet(comp, left, 1'b1), left, 1'b0);
            while (grown != comp) begin
                comp = grown;
                grown = closeSet(closeSet(comp, left, 1'b1), left, 1'b0);
            end
            left = left & ~comp;
            n++;
        end
        return n;
    endfunction

    task automatic loadTable();
        jobs[0]  = makeEntry(128'h0, 1'b1, 6'd0);
        jobs[1]  = makeEntry({128{1'b1}}, 1'b1, 6'd1);
        jobs[2]  = makeEntry(128'h0000_0020_0000_0000, 1'b1, 6'd1);
        jobs[3]  = makeEntry(128'h8000_0000_0000_0000_0000_0000_0000_0000, 1'b1, 6'd1);
        jobs[4]  = makeEntry(128'h1, 1'b1, 6'd1);
        jobs[5]  = makeEntry(128'h8000_0000_0000_0000_0000_0000_0000_0001, 1'b1, 6'd1);
        // Four incomparable vertices
        jobs[6]  = makeEntry(128'h116, 1'b1, 6'd4);
        jobs[7]  = makeEntry(128'h60, 1'b1, 6'd2);
        jobs[8]  = makeEntry(128'hE, 1'b1, 6'd1);
        // Chains 1-3-7 and 8-24-56
        jobs[9]  = makeEntry(128'h0100_0000_0100_018A, 1'b1, 6'd2);
        // Zigzag 1,3,2,6,4,...,96,64 that needs several closure rounds
        jobs[10] = makeEntry(128'h0000_0001_0000_0001_0001_0001_0101_115E, 1'b1, 6'd1);
        // Declined slot that must never complete
        jobs[11] = makeEntry({128{1'b1}}, 1'b0, 6'd0);
    endtask

    task automatic printCounts(input int timedOut);
        $display("errors: %0d value mismatches, %0d other failures, %0d timeouts",
            valueErrors, otherErrors, timedOut);
    endtask

    // Answer each request with the next job, or decline once all are sent
    always @(posedge clk) begin
        if (rstN && request && nextJob < NUM_JOBS) begin
            graphIn      <= jobs[nextJob].graph;
            graphInValid <= jobs[nextJob].valid;
            tagIn        <= 8'(nextJob);
            nextJob++;
        end else begin
            graphIn      <= '0;
            graphInValid <= 1'b0;
            tagIn        <= '0;
        end
    end

    always @(posedge clk) begin
        requestHist <= {requestHist[`DATA_IN_LATENCY-1:0], request};
        if (rstN && done) begin
            // The slot asked for its graph one input latency before its start stage
            assert (requestHist[`DATA_IN_LATENCY]) else begin
                otherErrors++;
                $display("done for tag 0x%02h did not come two cycles after a request",
                    tagOut);
            end
            assert (tagOut < NUM_JOBS) else begin
                valueErrors++;
                $display("[ERROR] tagOut: expected below 0x%02h, got 0x%02h", NUM_JOBS, tagOut);
            end
            if (tagOut < NUM_JOBS) begin
                assert (jobs[tagOut].valid) else begin
                    otherErrors++;
                    $display("done was raised for tag 0x%02h, which was sent as invalid", tagOut);
                end
                assert (!finished[tagOut]) else begin
                    otherErrors++;
                    $display("done was raised a second time for tag 0x%02h", tagOut);
                end
                assert (connectCount == jobs[tagOut].count) else begin
                    valueErrors++;
                    $display("[ERROR] connectCount for tag 0x%02h: expected 0x%02h, got 0x%02h",
                        tagOut, jobs[tagOut].count, connectCount);
                end
                if (jobs[tagOut].valid && !finished[tagOut]) begin
                    completed++;
                end
                finished[tagOut] = 1'b1;
            end
        end
    end

    initial begin
        logic [`GRAPH_WIDTH-1:0] a;
        logic [`GRAPH_WIDTH-1:0] b;
        loadTable();
        rngState = 32'he5b22095;
        for (int i = TABLE_SIZE; i < NUM_JOBS; i++) begin
            for (int w = 0; w < `GRAPH_WIDTH / 32; w++) begin
                rngState = xorshift32(rngState);
                a[32*w +: 32] = rngState;
                rngState = xorshift32(rngState);
                b[32*w +: 32] = rngState;
            end
            jobs[i] = makeEntry(a & b, 1'b1, 6'(countComponents(a & b)));
        end
        for (int i = 0; i < NUM_JOBS; i++) begin
            if (jobs[i].valid) begin
                validJobs++;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        wait (completed == validJobs);
        // Let the ring turn a few more times to catch stray done pulses
        repeat (4 * `LOOP_DEPTH) @(posedge clk);
        printCounts(0);
        if (valueErrors + otherErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with %0d of %0d graphs done",
            TIMEOUT_NS, completed, validJobs);
        for (int i = 0; i < NUM_JOBS; i++) begin
            if (jobs[i].valid && !finished[i]) begin
                $display("Tag 0x%02h never completed", i);
            end
        end
        printCounts(1);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
